// ==== run.sh ====
#!/bin/sh
# builds the core testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbMipsCore \
	-f sim.f \
	--Mdir obj_dir \
	-o tbMipsCore

# a failing check ends in $fatal, so a non-zero status stops the script here
./obj_dir/tbMipsCore

// ==== sim.f ====
src/mipsPkg.sv
src/divIf.sv
src/pipeReg.sv
src/regFile.sv
src/decodeUnit.sv
src/hazardUnit.sv
src/executeUnit.sv
src/serialDivider.sv
src/mipsCore.sv
tb/mipsCore_assert.sv
tb/tbMipsCore.sv

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
	input logic [mipsPkg::dataWidth-1:0] instr,
	output mipsPkg::decodeCtrlT ctrl,
	output logic [mipsPkg::regAddrWidth-1:0] rs,
	output logic [mipsPkg::regAddrWidth-1:0] rt,
	output logic [mipsPkg::dataWidth-1:0] imm,
	output logic [mipsPkg::shamtWidth-1:0] shamt
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [mipsPkg::regAddrWidth-1:0] rd;
	logic [mipsPkg::dataWidth-1:0] immSign;
	logic [mipsPkg::dataWidth-1:0] immZero;
	logic iType;

	// field split
	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];

	assign immSign = {{16{instr[15]}}, instr[15:0]};
	assign immZero = {16'h0000, instr[15:0]};

	always_comb begin
		ctrl = '0;
		imm = '0;
		iType = 1'b0;
		case (opcode)
			mipsPkg::opSpecial: begin
				// r-type writes rd unless cleared below
				ctrl.dest = rd;
				ctrl.regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAdd, mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub, mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnXor: ctrl.aluOp = mipsPkg::aluXor;
					mipsPkg::fnNor: ctrl.aluOp = mipsPkg::aluNor;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
					mipsPkg::fnSll: ctrl.aluOp = mipsPkg::aluSll;
					mipsPkg::fnSrl: ctrl.aluOp = mipsPkg::aluSrl;
					mipsPkg::fnSra: ctrl.aluOp = mipsPkg::aluSra;
					mipsPkg::fnMfhi: ctrl.wbSrc = mipsPkg::wbHi;
					mipsPkg::fnMflo: ctrl.wbSrc = mipsPkg::wbLo;
					mipsPkg::fnMult, mipsPkg::fnMultu: begin
						ctrl.regWrite = 1'b0;
						ctrl.mdWrite = 1'b1;
						ctrl.isSigned = (funct == mipsPkg::fnMult);
					end
					mipsPkg::fnDiv, mipsPkg::fnDivu: begin
						ctrl.regWrite = 1'b0;
						ctrl.mdWrite = 1'b1;
						ctrl.isDiv = 1'b1;
						ctrl.isSigned = (funct == mipsPkg::fnDiv);
					end
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			mipsPkg::opAddi, mipsPkg::opAddiu: begin
				iType = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
				imm = immSign;
			end
			mipsPkg::opSlti: begin
				iType = 1'b1;
				ctrl.aluOp = mipsPkg::aluSlt;
				imm = immSign;
			end
			mipsPkg::opAndi: begin
				iType = 1'b1;
				ctrl.aluOp = mipsPkg::aluAnd;
				imm = immZero;
			end
			mipsPkg::opOri: begin
				iType = 1'b1;
				ctrl.aluOp = mipsPkg::aluOr;
				imm = immZero;
			end
			mipsPkg::opXori: begin
				iType = 1'b1;
				ctrl.aluOp = mipsPkg::aluXor;
				imm = immZero;
			end
			mipsPkg::opLui: begin
				iType = 1'b1;
				ctrl.aluOp = mipsPkg::aluLui;
				imm = {instr[15:0], 16'h0000};
			end
			default: iType = 1'b0;
		endcase
		// immediate forms write rt
		if (iType) begin
			ctrl.useImm = 1'b1;
			ctrl.regWrite = 1'b1;
			ctrl.dest = rt;
		end
		// r0 writes are dropped here, so no stage ever sees them
		ctrl.regWrite = ctrl.regWrite && (ctrl.dest != '0);
	end

endmodule

`default_nettype wire

// ==== src/divIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// four-phase link between execute and the divider
interface divIf;
	logic req;
	logic ack;
	logic isSigned;
	logic [mipsPkg::dataWidth-1:0] dividend;
	logic [mipsPkg::dataWidth-1:0] divisor;
	logic [mipsPkg::dataWidth-1:0] quotient;
	logic [mipsPkg::dataWidth-1:0] remainder;

	// execute side, operands held until ack
	modport requester (
		output req, isSigned, dividend, divisor,
		input ack, quotient, remainder
	);

	// divider side, results held while ack
	modport server (
		input req, isSigned, dividend, divisor,
		output ack, quotient, remainder
	);
endinterface

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input logic clk,
	input logic rst,
	input mipsPkg::deStageT de,
	input logic [1:0] fwdA,
	input logic [1:0] fwdB,
	input mipsPkg::emStageT emFwd,
	input mipsPkg::mwStageT mwFwd,
	divIf.requester divLink,
	output logic divBusy,
	output mipsPkg::emStageT em
);

	typedef enum logic [1:0] {stIdle, stWait, stRelease} reqStateT;

	logic [mipsPkg::dataWidth-1:0] opA;
	logic [mipsPkg::dataWidth-1:0] opBReg;
	logic [mipsPkg::dataWidth-1:0] opB;
	logic [mipsPkg::dataWidth-1:0] aluOut;
	logic signed [2*mipsPkg::dataWidth-1:0] prodS;
	logic [2*mipsPkg::dataWidth-1:0] prodU;
	logic [2*mipsPkg::dataWidth-1:0] product;
	logic [mipsPkg::dataWidth-1:0] hiReg;
	logic [mipsPkg::dataWidth-1:0] loReg;
	logic [mipsPkg::dataWidth-1:0] hiVal;
	logic [mipsPkg::dataWidth-1:0] loVal;
	reqStateT state;
	logic resultReady;
	logic startDiv;
	logic takeResult;
	logic [mipsPkg::dataWidth-1:0] dividendQ;
	logic [mipsPkg::dataWidth-1:0] divisorQ;
	logic signedQ;
	logic [mipsPkg::dataWidth-1:0] quotQ;
	logic [mipsPkg::dataWidth-1:0] remQ;

	// ==================================================
	// operand forwarding
	// ==================================================
	assign opA = (fwdA == mipsPkg::fwdMem) ? emFwd.result :
		(fwdA == mipsPkg::fwdWb) ? mwFwd.result : de.rsVal;
	assign opBReg = (fwdB == mipsPkg::fwdMem) ? emFwd.result :
		(fwdB == mipsPkg::fwdWb) ? mwFwd.result : de.rtVal;
	assign opB = de.ctrl.useImm ? de.imm : opBReg;

	// ==================================================
	// alu and multiplier
	// ==================================================
	always_comb begin
		case (de.ctrl.aluOp)
			mipsPkg::aluAdd: aluOut = opA + opB;
			mipsPkg::aluSub: aluOut = opA - opB;
			mipsPkg::aluAnd: aluOut = opA & opB;
			mipsPkg::aluOr: aluOut = opA | opB;
			mipsPkg::aluXor: aluOut = opA ^ opB;
			mipsPkg::aluNor: aluOut = ~(opA | opB);
			mipsPkg::aluSlt: aluOut = {31'd0, $signed(opA) < $signed(opB)};
			mipsPkg::aluSltu: aluOut = {31'd0, opA < opB};
			// shifts act on rt by shamt
			mipsPkg::aluSll: aluOut = opB << de.shamt;
			mipsPkg::aluSrl: aluOut = opB >> de.shamt;
			mipsPkg::aluSra: aluOut = $signed(opB) >>> de.shamt;
			mipsPkg::aluLui: aluOut = opB;
			default: aluOut = '0;
		endcase
	end

	// full 64-bit products, rs times rt
	assign prodS = $signed(opA) * $signed(opBReg);
	assign prodU = opA * opBReg;
	assign product = de.ctrl.isSigned ? prodS : prodU;

	// ==================================================
	// hi/lo, written from the memory stage
	// ==================================================
	always_ff @(posedge clk) begin
		if (emFwd.hiloWrite) begin
			hiReg <= emFwd.hi;
			loReg <= emFwd.lo;
		end
	end

	// mult/div one ahead still in memory
	assign hiVal = emFwd.hiloWrite ? emFwd.hi : hiReg;
	assign loVal = emFwd.hiloWrite ? emFwd.lo : loReg;

	// ==================================================
	// divider request side
	// ==================================================
	// start once per divide, never while the last ack is still up
	assign startDiv = de.ctrl.isDiv && !resultReady && state != stWait && !divLink.ack;
	assign takeResult = (state == stWait) && divLink.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			resultReady <= 1'b0;
		end else begin
			// high for the single cycle in which the divide leaves execute
			resultReady <= takeResult;
			case (state)
				stWait: begin
					if (divLink.ack) begin
						state <= stRelease;
					end
				end
				default: begin
					if (startDiv) begin
						state <= stWait;
					end else if (!divLink.ack) begin
						state <= stIdle;
					end
				end
			endcase
		end
	end

	// operands frozen at entry, forwarding sources drain during the stall
	always_ff @(posedge clk) begin
		if (startDiv) begin
			dividendQ <= opA;
			divisorQ <= opBReg;
			signedQ <= de.ctrl.isSigned;
		end
		if (takeResult) begin
			quotQ <= divLink.quotient;
			remQ <= divLink.remainder;
		end
	end

	assign divLink.req = (state == stWait);
	assign divLink.dividend = dividendQ;
	assign divLink.divisor = divisorQ;
	assign divLink.isSigned = signedQ;

	assign divBusy = de.ctrl.isDiv && !resultReady;

	// ==================================================
	// stage output
	// ==================================================
	always_comb begin
		em.regWrite = de.ctrl.regWrite;
		em.dest = de.ctrl.dest;
		case (de.ctrl.wbSrc)
			mipsPkg::wbHi: em.result = hiVal;
			mipsPkg::wbLo: em.result = loVal;
			default: em.result = aluOut;
		endcase
		em.hiloWrite = de.ctrl.mdWrite;
		// divide: remainder to hi, quotient to lo
		em.hi = de.ctrl.isDiv ? remQ : product[2*mipsPkg::dataWidth-1:mipsPkg::dataWidth];
		em.lo = de.ctrl.isDiv ? quotQ : product[mipsPkg::dataWidth-1:0];
	end

endmodule

`default_nettype wire

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input logic [mipsPkg::regAddrWidth-1:0] deRs,
	input logic [mipsPkg::regAddrWidth-1:0] deRt,
	input logic emRegWrite,
	input logic [mipsPkg::regAddrWidth-1:0] emDest,
	input logic mwRegWrite,
	input logic [mipsPkg::regAddrWidth-1:0] mwDest,
	input logic divBusy,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic stall
);

	logic memHitA;
	logic memHitB;
	logic wbHitA;
	logic wbHitB;

	// r0 is a constant, never forwarded
	assign memHitA = emRegWrite && emDest != '0 && emDest == deRs;
	assign memHitB = emRegWrite && emDest != '0 && emDest == deRt;
	assign wbHitA = mwRegWrite && mwDest != '0 && mwDest == deRs;
	assign wbHitB = mwRegWrite && mwDest != '0 && mwDest == deRt;

	// younger result wins
	assign fwdA = memHitA ? mipsPkg::fwdMem : (wbHitA ? mipsPkg::fwdWb : mipsPkg::fwdReg);
	assign fwdB = memHitB ? mipsPkg::fwdMem : (wbHitB ? mipsPkg::fwdWb : mipsPkg::fwdReg);

	// only a divide in execute stalls the front end
	assign stall = divBusy;

endmodule

`default_nettype wire

// ==== src/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input logic clk,
	input logic rst,
	input logic [mipsPkg::dataWidth-1:0] instr,
	output logic [mipsPkg::dataWidth-1:0] pc,
	output logic wbEn,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0] wbData
);

	logic stall;
	logic divBusy;
	logic [1:0] fwdA;
	logic [1:0] fwdB;
	logic [mipsPkg::dataWidth-1:0] instrD;
	mipsPkg::decodeCtrlT ctrlD;
	logic [mipsPkg::regAddrWidth-1:0] rsD;
	logic [mipsPkg::regAddrWidth-1:0] rtD;
	logic [mipsPkg::dataWidth-1:0] rsValD;
	logic [mipsPkg::dataWidth-1:0] rtValD;
	logic [mipsPkg::dataWidth-1:0] immD;
	logic [mipsPkg::shamtWidth-1:0] shamtD;
	mipsPkg::deStageT deD;
	mipsPkg::deStageT deQ;
	mipsPkg::emStageT emD;
	mipsPkg::emStageT emQ;
	mipsPkg::mwStageT mwD;
	mipsPkg::mwStageT mwQ;

	divIf divLink ();

	// ==================================================
	// fetch
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instrD <= '0;
		end else if (!stall) begin
			pc <= pc + 32'd4;
			instrD <= instr;
		end
	end

	// ==================================================
	// decode
	// ==================================================
	decodeUnit u_decode (
		.instr(instrD),
		.ctrl(ctrlD),
		.rs(rsD),
		.rt(rtD),
		.imm(immD),
		.shamt(shamtD)
	);

	// written from writeback
	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.we(mwQ.regWrite),
		.wAddr(mwQ.dest),
		.wData(mwQ.result),
		.rAddrA(rsD),
		.rAddrB(rtD),
		.rDataA(rsValD),
		.rDataB(rtValD)
	);

	assign deD = '{ctrl: ctrlD, rs: rsD, rt: rtD, rsVal: rsValD, rtVal: rtValD,
		imm: immD, shamt: shamtD};

	// divide holds here while it runs
	pipeReg #(.payloadT(mipsPkg::deStageT)) u_deReg (
		.clk(clk),
		.rst(rst),
		.hold(stall),
		.bubble(1'b0),
		.d(deD),
		.q(deQ)
	);

	// ==================================================
	// execute
	// ==================================================
	hazardUnit u_hazard (
		.deRs(deQ.rs),
		.deRt(deQ.rt),
		.emRegWrite(emQ.regWrite),
		.emDest(emQ.dest),
		.mwRegWrite(mwQ.regWrite),
		.mwDest(mwQ.dest),
		.divBusy(divBusy),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall)
	);

	executeUnit u_execute (
		.clk(clk),
		.rst(rst),
		.de(deQ),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.emFwd(emQ),
		.mwFwd(mwQ),
		.divLink(divLink.requester),
		.divBusy(divBusy),
		.em(emD)
	);

	serialDivider u_divider (
		.clk(clk),
		.rst(rst),
		.link(divLink.server)
	);

	// bubbles fill memory while execute is stalled
	pipeReg #(.payloadT(mipsPkg::emStageT)) u_emReg (
		.clk(clk),
		.rst(rst),
		.hold(1'b0),
		.bubble(stall),
		.d(emD),
		.q(emQ)
	);

	// ==================================================
	// memory and writeback
	// ==================================================
	// no data memory, the result passes straight on
	assign mwD = '{regWrite: emQ.regWrite, dest: emQ.dest, result: emQ.result};

	pipeReg #(.payloadT(mipsPkg::mwStageT)) u_mwReg (
		.clk(clk),
		.rst(rst),
		.hold(1'b0),
		.bubble(1'b0),
		.d(mwD),
		.q(mwQ)
	);

	assign wbEn = mwQ.regWrite;
	assign wbReg = mwQ.dest;
	assign wbData = mwQ.result;

endmodule

`default_nettype wire

// ==== src/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// ==================================================
	// widths
	// ==================================================
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int shamtWidth = 5;

	// one quotient bit per divider step
	localparam int divSteps = dataWidth;
	localparam int divCntWidth = $clog2(divSteps);
	localparam logic [divCntWidth-1:0] divLastCount = divCntWidth'(divSteps - 1);

	// execute operand source
	localparam logic [1:0] fwdReg = 2'b00;
	localparam logic [1:0] fwdWb = 2'b01;
	localparam logic [1:0] fwdMem = 2'b10;

	// ==================================================
	// opcodes and funct codes
	// ==================================================
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opXori = 6'h0e;
	localparam logic [5:0] opLui = 6'h0f;

	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnMfhi = 6'h10;
	localparam logic [5:0] fnMflo = 6'h12;
	localparam logic [5:0] fnMult = 6'h18;
	localparam logic [5:0] fnMultu = 6'h19;
	localparam logic [5:0] fnDiv = 6'h1a;
	localparam logic [5:0] fnDivu = 6'h1b;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	// ==================================================
	// control and stage payloads
	// ==================================================
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOpT;

	// writeback value source
	typedef enum logic [1:0] {wbAlu, wbHi, wbLo} wbSrcT;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		logic regWrite;
		logic [regAddrWidth-1:0] dest;
		wbSrcT wbSrc;
		// writes hi/lo
		logic mdWrite;
		logic isDiv;
		logic isSigned;
	} decodeCtrlT;

	typedef struct packed {
		decodeCtrlT ctrl;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [dataWidth-1:0] rsVal;
		logic [dataWidth-1:0] rtVal;
		logic [dataWidth-1:0] imm;
		logic [shamtWidth-1:0] shamt;
	} deStageT;

	typedef struct packed {
		logic regWrite;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] result;
		logic hiloWrite;
		logic [dataWidth-1:0] hi;
		logic [dataWidth-1:0] lo;
	} emStageT;

	typedef struct packed {
		logic regWrite;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] result;
	} mwStageT;

endpackage

`default_nettype wire

// ==== src/pipeReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic bubble,
	input payloadT d,
	output payloadT q
);

	// all-zero payload decodes as a no-op
	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [mipsPkg::regAddrWidth-1:0] wAddr,
	input logic [mipsPkg::dataWidth-1:0] wData,
	input logic [mipsPkg::regAddrWidth-1:0] rAddrA,
	input logic [mipsPkg::regAddrWidth-1:0] rAddrB,
	output logic [mipsPkg::dataWidth-1:0] rDataA,
	output logic [mipsPkg::dataWidth-1:0] rDataB
);

	logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];

	// register 0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// write-before-read bypass for the decode stage
	assign rDataA = (rAddrA == '0) ? '0 :
		(we && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (rAddrB == '0) ? '0 :
		(we && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

`default_nettype wire

// ==== src/serialDivider.sv ====
`timescale 1ns/1ps
`default_nettype none

module serialDivider (
	input logic clk,
	input logic rst,
	divIf.server link
);

	typedef enum logic [1:0] {sIdle, sRun, sAck} divStateT;

	divStateT state;
	logic [mipsPkg::divCntWidth-1:0] count;
	logic lastStep;
	logic [mipsPkg::dataWidth-1:0] dividendAbs;
	logic [mipsPkg::dataWidth-1:0] divisorIn;
	logic [mipsPkg::dataWidth-1:0] quo;
	logic [mipsPkg::dataWidth-1:0] rem;
	logic [mipsPkg::dataWidth-1:0] divisorAbs;
	logic [mipsPkg::dataWidth-1:0] nextQuo;
	logic [mipsPkg::dataWidth-1:0] nextRem;
	logic [mipsPkg::dataWidth:0] shifted;
	logic [mipsPkg::dataWidth:0] diff;
	logic negQuot;
	logic negRem;

	// magnitudes of the operands
	assign dividendAbs = (link.isSigned && link.dividend[mipsPkg::dataWidth-1]) ?
		-link.dividend : link.dividend;
	assign divisorIn = (link.isSigned && link.divisor[mipsPkg::dataWidth-1]) ?
		-link.divisor : link.divisor;

	// restoring step, next dividend bit shifted into the partial remainder
	assign shifted = {rem, quo[mipsPkg::dataWidth-1]};
	assign diff = shifted - {1'b0, divisorAbs};
	assign nextRem = diff[mipsPkg::dataWidth] ? shifted[mipsPkg::dataWidth-1:0] :
		diff[mipsPkg::dataWidth-1:0];
	assign nextQuo = {quo[mipsPkg::dataWidth-2:0], ~diff[mipsPkg::dataWidth]};

	assign lastStep = (state == sRun) && (count == mipsPkg::divLastCount);

	// ==================================================
	// handshake and step count
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sIdle;
			count <= '0;
			link.ack <= 1'b0;
		end else begin
			case (state)
				sIdle: begin
					if (link.req) begin
						state <= sRun;
						count <= '0;
					end
				end
				sRun: begin
					count <= count + 1'b1;
					// results go out with ack after the last step
					if (lastStep) begin
						state <= sAck;
						link.ack <= 1'b1;
					end
				end
				default: begin
					if (!link.req) begin
						state <= sIdle;
						link.ack <= 1'b0;
					end
				end
			endcase
		end
	end

	// ==================================================
	// datapath
	// ==================================================
	always_ff @(posedge clk) begin
		if (state == sIdle && link.req) begin
			quo <= dividendAbs;
			rem <= '0;
			divisorAbs <= divisorIn;
			// quotient sign from the product, remainder follows the dividend
			negQuot <= link.isSigned &&
				(link.dividend[mipsPkg::dataWidth-1] ^ link.divisor[mipsPkg::dataWidth-1]);
			negRem <= link.isSigned && link.dividend[mipsPkg::dataWidth-1];
		end else if (state == sRun) begin
			quo <= nextQuo;
			rem <= nextRem;
			if (lastStep) begin
				link.quotient <= negQuot ? -nextQuo : nextQuo;
				link.remainder <= negRem ? -nextRem : nextRem;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/corePatterns.mem ====
// from @00: one instruction word per line
// at @40: count of expected writebacks, then pairs of register and value in program order
@00
20010005 // addi r1, r0, 5
2002fffd // addi r2, r0, -3
00221820 // add  r3, r1, r2
00612022 // sub  r4, r3, r1
00412824 // and  r5, r2, r1
00813025 // or   r6, r4, r1
00413826 // xor  r7, r2, r1
00204027 // nor  r8, r1, r0
0041482a // slt  r9, r2, r1
0041502b // sltu r10, r2, r1
00015900 // sll  r11, r1, 4
00026702 // srl  r12, r2, 28
00026843 // sra  r13, r2, 1
284efffe // slti r14, r2, -2
304f8fff // andi r15, r2, 0x8fff
34108001 // ori  r16, r0, 0x8001
3a11ffff // xori r17, r16, 0xffff
3c128765 // lui  r18, 0x8765
00410018 // mult r2, r1
00009810 // mfhi r19
0000a012 // mflo r20
00410019 // multu r2, r1
0000a812 // mflo r21
0000b010 // mfhi r22
2017ffef // addi r23, r0, -17
02e1001a // div  r23, r1
0000c012 // mflo r24
0000c810 // mfhi r25
02e1001b // divu r23, r1
203d0064 // addi r29, r1, 100
0000f012 // mflo r30
0022001a // div  r1, r2
0000d010 // mfhi r26
0000d812 // mflo r27
0341e020 // add  r28, r26, r1
@40
0000001e
00000001 00000005  00000002 fffffffd  00000003 00000002  00000004 fffffffd
00000005 00000005  00000006 fffffffd  00000007 fffffff8  00000008 fffffffa
00000009 00000001  0000000a 00000000  0000000b 00000050  0000000c 0000000f
0000000d fffffffe  0000000e 00000001  0000000f 00008ffd  00000010 00008001
00000011 00007ffe  00000012 87650000  00000013 ffffffff  00000014 fffffff1
00000015 fffffff1  00000016 00000004  00000017 ffffffef  00000018 fffffffd
00000019 fffffffe  0000001d 00000069  0000001e 3333332f  0000001a 00000002
0000001b ffffffff  0000001c 00000007

// ==== tb/mipsCore_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol rules on the divider link and the fetch stage
module coreProtocolCheck (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic stall,
	input logic [mipsPkg::dataWidth-1:0] pc
);

	// requester keeps req up until the divider answers
	reqHeld: assert property (@(posedge clk) disable iff (rst) req && !ack |=> req)
		else $error("divider req dropped before ack");

	// divider only answers an open request
	ackOnlyWithReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
		else $error("divider ack rose while req was low");

	// fetch frozen for the whole divide
	pcHeld: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc))
		else $error("pc moved while the pipeline was stalled");

endmodule

// divLink is the link between execute and serialDivider
bind mipsCore coreProtocolCheck u_protocolCheck (
	.clk(clk),
	.rst(rst),
	.req(divLink.req),
	.ack(divLink.ack),
	.stall(stall),
	.pc(pc)
);

`default_nettype wire

// ==== tb/tbMipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore;

	localparam int clkPeriod = 100;
	// program words live below this index, the count word sits on it
	localparam int progWords = 64;
	localparam int memWords = 128;
	localparam int wbTimeout = 200;
	// quiet cycles watched after the last expected writeback
	localparam int idleWindow = 40;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic [31:0] pc;
	logic wbEn;
	logic [4:0] wbReg;
	logic [31:0] wbData;

	logic [31:0] patterns [memWords];
	int expCount;

	mipsCore u_dut (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.pc(pc),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ==================================================
	// instruction memory model
	// ==================================================
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		int idx;
		idx = int'(addr[31:2]);
		// zero past the program area is a no-op
		if (idx < progWords) begin
			fetchWord = patterns[idx];
		end else begin
			fetchWord = '0;
		end
	endfunction

	// new word 1 ns after the edge that moved pc
	always @(posedge clk) begin
		#1;
		instr = fetchWord(pc);
	end

	// ==================================================
	// checking helpers
	// ==================================================
	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic waitWriteback(input int index);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (wbEn !== 1'b1 && cycles < wbTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (wbEn !== 1'b1) begin
			stopOnError($sformatf("no writeback arrived within %0d cycles for expected entry %0d",
				wbTimeout, index));
		end
	endtask

	task automatic checkWriteback(input logic [4:0] expReg, input logic [31:0] expData);
		assert (wbReg === expReg) else begin
			stopOnError($sformatf("[FAIL] t=%0t wbReg got %0d expected %0d",
				$time, wbReg, expReg));
		end
		assert (wbData === expData) else begin
			stopOnError($sformatf("[FAIL] t=%0t wbData got %h expected %h",
				$time, wbData, expData));
		end
	endtask

	task automatic checkNoExtraWriteback();
		for (int c = 0; c < idleWindow; c++) begin
			@(negedge clk);
			assert (wbEn !== 1'b1) else begin
				stopOnError($sformatf("writeback to r%0d at t=%0t is beyond the expected list",
					wbReg, $time));
			end
		end
	endtask

	// ==================================================
	// stimulus and checks
	// ==================================================
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		// ori r0, r0, index as filler, a no-op that still tracks the address
		for (int i = 0; i < memWords; i++) begin
			patterns[i] = {6'h0d, 10'd0, i[15:0]};
		end
		$readmemh("tb/corePatterns.mem", patterns);
		expCount = int'(patterns[progWords]);
		if (expCount < 1 || expCount > (memWords - progWords - 1) / 2) begin
			stopOnError("pattern file does not hold a usable writeback count");
		end

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// first four cycles: pc steps by four, nothing reaches writeback
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			assert (pc === 32'(4 * k)) else begin
				stopOnError($sformatf("[FAIL] t=%0t pc got %h expected %h",
					$time, pc, 32'(4 * k)));
			end
			assert (wbEn === 1'b0) else begin
				stopOnError($sformatf("[FAIL] t=%0t wbEn got %b expected 0", $time, wbEn));
			end
		end

		// writebacks in program order
		for (int n = 0; n < expCount; n++) begin
			waitWriteback(n);
			checkWriteback(patterns[progWords + 1 + 2 * n][4:0],
				patterns[progWords + 2 + 2 * n]);
		end

		checkNoExtraWriteback();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
